/* filelist.f */
+incdir+hdl
hdl/cpuPkg.sv
hdl/ctrlBus_if.sv
hdl/aluUnit.sv
hdl/microSequencer.sv
hdl/dataPath.sv
hdl/mainMemory.sv
hdl/cpuTop.sv
testbench/cpu_chk.sv
testbench/cpuTb.sv

/* hdl/aluUnit.sv */
//##########################################################
// ALU
// six function bits plus carry-in, flags from the result
//##########################################################

`timescale 1ns/1ps

`include "cpu_config.svh"

module aluUnit (
    input  logic [`CPU_DATA_WIDTH-1:0] xVal,
    input  logic [`CPU_DATA_WIDTH-1:0] yVal,
    input  cpuPkg::aluFn_t             fn,
    input  logic                       carryIn,
    output logic [`CPU_DATA_WIDTH-1:0] result,
    output logic                       carryOut,
    output logic                       zero,
    output logic                       less
);

    logic [`CPU_DATA_WIDTH-1:0] xZero;
    logic [`CPU_DATA_WIDTH-1:0] yZero;
    logic [`CPU_DATA_WIDTH-1:0] xOp;
    logic [`CPU_DATA_WIDTH-1:0] yOp;
    logic [`CPU_DATA_WIDTH:0]   sum;
    logic [`CPU_DATA_WIDTH-1:0] rawResult;

    // operand conditioning
    assign xZero = fn.enX ? xVal : '0;
    assign yZero = fn.enY ? yVal : '0;
    assign xOp   = fn.negX ? ~xZero : xZero;
    assign yOp   = fn.negY ? ~yZero : yZero;

    assign sum = {1'b0, xOp} + {1'b0, yOp} + {{`CPU_DATA_WIDTH{1'b0}}, carryIn};

    always_comb begin
        if (fn.addSel) begin
            rawResult = sum[`CPU_DATA_WIDTH-1:0];
            carryOut  = sum[`CPU_DATA_WIDTH];
        end else begin
            rawResult = xOp & yOp;
            carryOut  = 1'b0;   // no carry out of and
        end
    end

    assign result = fn.negOut ? ~rawResult : rawResult;

    assign zero = (result == '0);
    assign less = result[`CPU_DATA_WIDTH-1];   // sign bit

endmodule

/* hdl/cpuPkg.sv */
//##########################################################
// CPU package
// opcodes, bus sources, ALU function bits, control word
//##########################################################

`include "cpu_config.svh"

package cpuPkg;

    // IR[15:12]
    typedef enum logic [3:0] {
        NOP  = 4'h0,
        LDXI = 4'h1,
        LDYI = 4'h2,
        LDXM = 4'h3,
        LDYM = 4'h4,
        ALU  = 4'h5,
        STA  = 4'h6,
        JMP  = 4'h7,
        JC   = 4'h8,
        JZ   = 4'h9,
        JGT  = 4'hA,
        JLT  = 4'hB,
        OUT  = 4'hC,
        IN   = 4'hD,
        HLT  = 4'hE
    } opcode_t;

    // IR[5:0], enX is bit 5
    typedef struct packed {
        logic enX;
        logic negX;
        logic enY;
        logic negY;
        logic addSel;   // 1 = add, 0 = and
        logic negOut;
    } aluFn_t;

    typedef enum logic [2:0] {
        BUS_NONE = 3'd0,
        BUS_PC   = 3'd1,
        BUS_IRLO = 3'd2,    // IR[7:0]
        BUS_IR12 = 3'd3,    // IR[11:0]
        BUS_MEM  = 3'd4,
        BUS_ALU  = 3'd5,
        BUS_IN   = 3'd6
    } busSrc_t;

    typedef struct packed {
        busSrc_t busSrc;
        logic    xLoad;
        logic    yLoad;
        logic    arLoad;
        logic    irLoad;
        logic    memWrite;
        logic    pcInc;
        logic    pcLoad;
        logic    carryEn;
        logic    outStrobe;
        logic    tReset;
    } ctrlWord_t;

    typedef enum logic {
        SEQ_RUN  = 1'b0,
        SEQ_HALT = 1'b1
    } seqState_t;

    typedef logic [$clog2(`CPU_TSTATES)-1:0] tState_t;

endpackage

/* hdl/cpuTop.sv */
//##########################################################
// CPU top level
// sequencer, datapath and RAM behind plain ports
//##########################################################

`timescale 1ns/1ps

`include "cpu_config.svh"

module cpuTop (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       loadEn,
    input  logic [`CPU_ADDR_BITS-1:0]  loadAddr,
    input  logic [`CPU_DATA_WIDTH-1:0] loadData,
    input  logic [`CPU_DATA_WIDTH-1:0] inData,
    output logic [`CPU_DATA_WIDTH-1:0] outData,
    output logic                       outValid,
    output logic                       halted
);

    logic [`CPU_ADDR_BITS-1:0]  memAddr;
    logic [`CPU_DATA_WIDTH-1:0] memWrData;
    logic [`CPU_DATA_WIDTH-1:0] memRdData;
    logic                       memWrite;

    ctrlBus_if ctl ();

    microSequencer seqUnit (
        .clk    (clk),
        .reset  (reset),
        .ctl    (ctl),
        .halted (halted)
    );

    dataPath dpUnit (
        .clk       (clk),
        .reset     (reset),
        .ctl       (ctl),
        .memRdData (memRdData),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memWrite  (memWrite),
        .inData    (inData),
        .outData   (outData),
        .outValid  (outValid)
    );

    mainMemory memUnit (
        .clk      (clk),
        .reset    (reset),
        .addr     (memAddr),
        .wrData   (memWrData),
        .wrEn     (memWrite),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdData   (memRdData)
    );

endmodule

/* hdl/cpu_config.svh */
//##########################################################
// CPU configuration
// word width, memory size and T-states per instruction
//##########################################################

`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and bus width
`define CPU_DATA_WIDTH 16

// internal RAM
`define CPU_MEM_DEPTH 256
`define CPU_ADDR_BITS 8

// fetch (2) plus up to three execute states
`define CPU_TSTATES 5

`endif

/* hdl/ctrlBus_if.sv */
//##########################################################
// Control bus between sequencer and datapath
// control word one way, opcode and flags back
//##########################################################

`timescale 1ns/1ps

interface ctrlBus_if;
    import cpuPkg::*;

    ctrlWord_t ctrl;
    opcode_t   opcode;
    logic      carryFlag;
    logic      zeroFlag;
    logic      lessFlag;

    modport seq (
        output ctrl,
        input  opcode, carryFlag, zeroFlag, lessFlag
    );

    modport dp (
        input  ctrl,
        output opcode, carryFlag, zeroFlag, lessFlag
    );

endinterface

/* hdl/dataPath.sv */
//##########################################################
// Datapath
// single internal bus, X/Y/AR/PC/IR, flags and output port
//##########################################################

`timescale 1ns/1ps

`include "cpu_config.svh"

module dataPath (
    input  logic                       clk,
    input  logic                       reset,
    ctrlBus_if.dp                      ctl,
    input  logic [`CPU_DATA_WIDTH-1:0] memRdData,
    output logic [`CPU_ADDR_BITS-1:0]  memAddr,
    output logic [`CPU_DATA_WIDTH-1:0] memWrData,
    output logic                       memWrite,
    input  logic [`CPU_DATA_WIDTH-1:0] inData,
    output logic [`CPU_DATA_WIDTH-1:0] outData,
    output logic                       outValid
);
    import cpuPkg::*;

    logic [`CPU_DATA_WIDTH-1:0] bus;
    logic [`CPU_DATA_WIDTH-1:0] xReg;
    logic [`CPU_DATA_WIDTH-1:0] yReg;
    logic [`CPU_DATA_WIDTH-1:0] irReg;
    logic [`CPU_ADDR_BITS-1:0]  arReg;
    logic [`CPU_ADDR_BITS-1:0]  pcReg;
    logic [2:0]                 flags;      // carry, zero, less
    logic [`CPU_DATA_WIDTH-1:0] aluResult;
    logic                       aluCarry;
    logic                       aluZero;
    logic                       aluLess;

    aluUnit alu (
        .xVal     (xReg),
        .yVal     (yReg),
        .fn       (aluFn_t'(irReg[5:0])),
        .carryIn  (flags[2] & ctl.ctrl.carryEn),
        .result   (aluResult),
        .carryOut (aluCarry),
        .zero     (aluZero),
        .less     (aluLess)
    );

    // one driver at a time
    always_comb begin
        case (ctl.ctrl.busSrc)
            BUS_PC:   bus = {{(`CPU_DATA_WIDTH-`CPU_ADDR_BITS){1'b0}}, pcReg};
            BUS_IRLO: bus = {{(`CPU_DATA_WIDTH-8){1'b0}}, irReg[7:0]};
            BUS_IR12: bus = {{(`CPU_DATA_WIDTH-12){1'b0}}, irReg[11:0]};
            BUS_MEM:  bus = memRdData;
            BUS_ALU:  bus = aluResult;
            BUS_IN:   bus = inData;
            default:  bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            xReg     <= '0;
            yReg     <= '0;
            irReg    <= '0;
            arReg    <= '0;
            pcReg    <= '0;
            flags    <= '0;
            outData  <= '0;
            outValid <= 1'b0;
        end else begin
            if (ctl.ctrl.xLoad) begin
                xReg <= bus;
            end
            if (ctl.ctrl.yLoad) begin
                yReg <= bus;
            end
            if (ctl.ctrl.irLoad) begin
                irReg <= bus;
            end
            if (ctl.ctrl.arLoad) begin
                arReg <= bus[`CPU_ADDR_BITS-1:0];
            end
            if (ctl.ctrl.pcLoad) begin
                pcReg <= bus[`CPU_ADDR_BITS-1:0];   // taken jump wins
            end else if (ctl.ctrl.pcInc) begin
                pcReg <= pcReg + 1'b1;
            end
            // flags follow every ALU bus cycle
            if (ctl.ctrl.busSrc == BUS_ALU) begin
                flags <= {aluCarry, aluZero, aluLess};
            end
            if (ctl.ctrl.outStrobe) begin
                outData <= bus;
            end
            outValid <= ctl.ctrl.outStrobe;
        end
    end

    assign memAddr   = arReg;
    assign memWrData = bus;
    assign memWrite  = ctl.ctrl.memWrite;

    assign ctl.opcode    = opcode_t'(irReg[`CPU_DATA_WIDTH-1 -: 4]);
    assign ctl.carryFlag = flags[2];
    assign ctl.zeroFlag  = flags[1];
    assign ctl.lessFlag  = flags[0];

endmodule

/* hdl/mainMemory.sv */
//##########################################################
// Main memory
// word RAM, async read, CPU writes or load-port writes
//##########################################################

`timescale 1ns/1ps

`include "cpu_config.svh"

module mainMemory (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CPU_ADDR_BITS-1:0]  addr,
    input  logic [`CPU_DATA_WIDTH-1:0] wrData,
    input  logic                       wrEn,
    input  logic                       loadEn,
    input  logic [`CPU_ADDR_BITS-1:0]  loadAddr,
    input  logic [`CPU_DATA_WIDTH-1:0] loadData,
    output logic [`CPU_DATA_WIDTH-1:0] rdData
);

    logic [`CPU_DATA_WIDTH-1:0] mem [`CPU_MEM_DEPTH];

    assign rdData = mem[addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            // program load only while held in reset
            if (loadEn) begin
                mem[loadAddr] <= loadData;
            end
        end else if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

endmodule

/* hdl/microSequencer.sv */
//##########################################################
// Microcode sequencer
// T-state counter, control word table, jump test, halt
//##########################################################

`timescale 1ns/1ps

`include "cpu_config.svh"

module microSequencer (
    input  logic  clk,
    input  logic  reset,
    ctrlBus_if.seq ctl,
    output logic  halted
);
    import cpuPkg::*;

    seqState_t state;
    tState_t   tState;
    ctrlWord_t cw;
    logic      jumpCond;
    logic      haltReq;

    // flag test for the conditional jumps
    always_comb begin
        case (ctl.opcode)
            JMP:     jumpCond = 1'b1;
            JC:      jumpCond = ctl.carryFlag;
            JZ:      jumpCond = ctl.zeroFlag;
            JLT:     jumpCond = ctl.lessFlag;
            JGT:     jumpCond = !ctl.zeroFlag && !ctl.lessFlag;
            default: jumpCond = 1'b0;
        endcase
    end

    always_comb begin
        cw      = '0;   // idle word
        haltReq = 1'b0;
        if (state == SEQ_RUN) begin
            case (tState)
                0: begin
                    cw.busSrc = BUS_PC;
                    cw.arLoad = 1'b1;
                end
                1: begin
                    cw.busSrc = BUS_MEM;
                    cw.irLoad = 1'b1;
                    cw.pcInc  = 1'b1;
                end
                2: begin
                    cw.tReset = 1'b1;   // most ops finish here
                    case (ctl.opcode)
                        LDXI: begin
                            cw.busSrc = BUS_IR12;
                            cw.xLoad  = 1'b1;
                        end
                        LDYI: begin
                            cw.busSrc = BUS_IR12;
                            cw.yLoad  = 1'b1;
                        end
                        LDXM, LDYM, STA: begin
                            cw.busSrc = BUS_IRLO;
                            cw.arLoad = 1'b1;
                            cw.tReset = 1'b0;
                        end
                        ALU: begin
                            cw.busSrc  = BUS_ALU;
                            cw.xLoad   = 1'b1;
                            cw.carryEn = 1'b1;
                        end
                        JMP, JC, JZ, JGT, JLT: begin
                            cw.busSrc = BUS_IRLO;
                            cw.pcLoad = jumpCond;
                        end
                        OUT: begin
                            cw.busSrc    = BUS_ALU;
                            cw.outStrobe = 1'b1;
                        end
                        IN: begin
                            cw.busSrc = BUS_IN;
                            cw.xLoad  = 1'b1;
                        end
                        HLT: haltReq = 1'b1;
                        default: ;
                    endcase
                end
                3: begin
                    cw.tReset = 1'b1;
                    case (ctl.opcode)
                        LDXM: begin
                            cw.busSrc = BUS_MEM;
                            cw.xLoad  = 1'b1;
                        end
                        LDYM: begin
                            cw.busSrc = BUS_MEM;
                            cw.yLoad  = 1'b1;
                        end
                        STA: begin
                            cw.busSrc   = BUS_ALU;
                            cw.memWrite = 1'b1;
                        end
                        default: ;
                    endcase
                end
                default: ;
            endcase
            // never run past the last slot
            if (tState >= tState_t'(`CPU_TSTATES - 1)) begin
                cw.tReset = 1'b1;
            end
        end
    end

    assign ctl.ctrl = cw;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= SEQ_RUN;
            tState <= '0;
        end else if (state == SEQ_HALT) begin
            tState <= '0;
        end else begin
            if (haltReq) begin
                state <= SEQ_HALT;
            end
            if (cw.tReset) begin
                tState <= '0;
            end else begin
                tState <= tState + 1'b1;
            end
        end
    end

    assign halted = (state == SEQ_HALT);

endmodule

/* testbench/cpuTb.sv */
//##########################################################
// CPU testbench
// random programs, instruction-level model, output scoreboard
//##########################################################

`timescale 1ns/1ps

`include "cpu_config.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int PROG_LEN     = 40;
    localparam int NUM_TESTS    = 5;
    localparam int RESET_CYCLES = 10;
    localparam int DEPTH        = `CPU_MEM_DEPTH;
    localparam int WATCHDOG_CYCLES = 5 * PROG_LEN * 4 * NUM_TESTS
                                   + NUM_TESTS * (DEPTH + RESET_CYCLES + 12);

    logic                       clk;
    logic                       reset;
    logic                       loadEn;
    logic [`CPU_ADDR_BITS-1:0]  loadAddr;
    logic [`CPU_DATA_WIDTH-1:0] loadData;
    logic [`CPU_DATA_WIDTH-1:0] inData;
    logic [`CPU_DATA_WIDTH-1:0] outData;
    logic                       outValid;
    logic                       halted;

    int          seed = 63092;
    logic [15:0] image [DEPTH];
    logic [15:0] modelMem [DEPTH];
    logic [15:0] expQ [$];
    logic [15:0] expVal;
    logic        mC, mZ, mL;    // model flags
    int          expCount, obsCount, testErrors, passCount, failCount;
    string       curName;

    cpuTop u_dut (
        .clk      (clk),
        .reset    (reset),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .inData   (inData),
        .outData  (outData),
        .outValid (outValid),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic string testName(input int t);
        case (t)
            0:       return "loadOut";
            1:       return "aluFunctions";
            2:       return "carryChain";
            3:       return "memRoundTrip";
            default: return "jumpsInHalt";
        endcase
    endfunction

    // allowed opcodes per test, one bit per opcode value
    function automatic logic [15:0] opMask(input int t);
        case (t)
            0:       return 16'h1006;
            1, 2:    return 16'h1026;
            3:       return 16'h107A;
            default: return 16'h3FA7;
        endcase
    endfunction

    // returns {carry, result}
    function automatic logic [16:0] aluEval(input logic [15:0] x, input logic [15:0] y,
                                            input logic [5:0] fn, input logic cin);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic        co;
        a = fn[5] ? x : 16'h0;
        if (fn[4]) a = ~a;
        b = fn[3] ? y : 16'h0;
        if (fn[2]) b = ~b;
        if (fn[1]) begin
            {co, res} = {1'b0, a} + {1'b0, b} + {16'h0, cin};
        end else begin
            res = a & b;
            co  = 1'b0;
        end
        if (fn[0]) res = ~res;
        return {co, res};
    endfunction

    task automatic updateFlags(input logic [16:0] r);
        mC = r[16];
        mZ = (r[15:0] == 16'h0);
        mL = r[15];
    endtask

    task automatic genProgram(input int t);
        logic [15:0] mask;
        logic [15:0] r;
        mask = opMask(t);
        for (int a = 0; a < DEPTH; a++) begin
            r = $random(seed);
            if (a == PROG_LEN - 1) begin
                image[a] = {HLT, r[11:0]};
            end else if (a < PROG_LEN - 1) begin
                while (!mask[r[15:12]]) r = $random(seed);
                case (opcode_t'(r[15:12]))
                    LDXM, LDYM, STA: r[7:0] = 8'd201 + 8'(r[7:0] % 55);    // data area only
                    JMP, JC, JZ, JGT, JLT: r[7:0] = 8'(a + 1 + (r[7:0] % (PROG_LEN - 1 - a)));
                    ALU: if (t == 2) r[1] = 1'b1;   // force add
                    default: ;
                endcase
                image[a] = r;
            end else if (a > 200) begin
                image[a] = r;
            end else begin
                image[a] = {a[7:0], ~a[7:0]};
            end
        end
    endtask

    task automatic runModel(input logic [15:0] inVal);
        int          pc;
        int          steps;
        logic [15:0] x, y, ir;
        logic [16:0] r;
        bit          done;
        pc = 0;
        steps = 0;
        x = 16'h0;
        y = 16'h0;
        done = 1'b0;
        {mC, mZ, mL} = 3'b000;
        modelMem = image;
        expQ.delete();
        while (!done && steps < 4 * PROG_LEN) begin
            ir = modelMem[pc];
            pc = (pc + 1) % DEPTH;
            steps++;
            case (opcode_t'(ir[15:12]))
                LDXI: x = {4'h0, ir[11:0]};
                LDYI: y = {4'h0, ir[11:0]};
                LDXM: x = modelMem[ir[7:0]];
                LDYM: y = modelMem[ir[7:0]];
                ALU: begin
                    r = aluEval(x, y, ir[5:0], mC);
                    x = r[15:0];
                    updateFlags(r);
                end
                STA: begin
                    r = aluEval(x, y, ir[5:0], 1'b0);
                    modelMem[ir[7:0]] = r[15:0];
                    updateFlags(r);
                end
                OUT: begin
                    r = aluEval(x, y, ir[5:0], 1'b0);
                    expQ.push_back(r[15:0]);
                    updateFlags(r);
                end
                JMP: pc = ir[7:0];
                JC:  if (mC) pc = ir[7:0];
                JZ:  if (mZ) pc = ir[7:0];
                JGT: if (!mZ && !mL) pc = ir[7:0];
                JLT: if (mL) pc = ir[7:0];
                IN:  x = inVal;
                HLT: done = 1'b1;
                default: ;
            endcase
        end
        expCount = expQ.size();
    endtask

    task automatic loadImage();
        for (int a = 0; a < DEPTH; a++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = `CPU_ADDR_BITS'(a);
            loadData = image[a];
        end
        @(negedge clk);
        loadEn = 1'b0;
    endtask

    task automatic runTest(input int t);
        @(negedge clk);
        reset      = 1'b1;
        inData     = $random(seed);
        curName    = testName(t);
        testErrors = 0;
        obsCount   = 0;
        genProgram(t);
        runModel(inData);
        loadImage();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        wait (halted === 1'b1);
        repeat (8) @(negedge clk);     // catch any late strobe
        assert (obsCount == expCount) else begin
            $display("CHECK FAILED %s output count expected %0d actual %0d",
                     curName, expCount, obsCount);
            testErrors++;
        end
        if (testErrors == 0) begin
            passCount++;
            $display("test %s: ok, %0d outputs", curName, obsCount);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", curName, testErrors);
        end
    endtask

    // scoreboard, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (outValid === 1'b1) begin
            obsCount++;
            assert (halted !== 1'b1) else begin
                $display("ERROR: %s produced an output after halting", curName);
                testErrors++;
            end
            assert (expQ.size() > 0) else begin
                $display("ERROR: %s produced more outputs than expected", curName);
                testErrors++;
            end
            if (expQ.size() > 0) begin
                expVal = expQ.pop_front();
                assert (outData === expVal) else begin
                    $display("CHECK FAILED %s expected %h actual %h", curName, expVal, outData);
                    testErrors++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired, the CPU never halted");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        inData    = '0;
        passCount = 0;
        failCount = 0;
        curName   = "";
        repeat (RESET_CYCLES) @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("summary: %0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/cpu_chk.sv */
//##########################################################
// CPU port checker
// concurrent assertions on reset, output strobe and halt
//##########################################################

`timescale 1ns/1ps

module cpuChk (
    input logic clk,
    input logic reset,
    input logic loadEn,
    input logic outValid,
    input logic halted
);

    outQuietInReset: assert property (@(posedge clk) reset |=> !outValid)
        else $error("outValid high during reset");

    outQuietAfterReset: assert property (@(posedge clk) $fell(reset) |=> !outValid)
        else $error("outValid high in the first cycle after reset");

    noOutWhenHalted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !$rose(outValid))
        else $error("outValid rose while halted");

    haltSticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
        else $error("halted dropped without reset");

    loadOnlyInReset: assert property (@(posedge clk) !reset |-> !loadEn)
        else $error("loadEn high outside reset");

endmodule

bind cpuTop cpuChk chk (
    .clk      (clk),
    .reset    (reset),
    .loadEn   (loadEn),
    .outValid (outValid),
    .halted   (halted)
);
